//--- hdl/ex_pkg.sv
package ex_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // alu control codes, 5 bits wide.
    typedef enum logic [4:0] {
        ADD   = 5'd0,
        SUB   = 5'd1,
        EQU   = 5'd2,
        NEQ   = 5'd3,
        SLT   = 5'd4,
        SGE   = 5'd5,
        SLTU  = 5'd6,
        SGEU  = 5'd7,
        XOR   = 5'd8,
        OR    = 5'd9,
        SLL   = 5'd10,
        SRL   = 5'd11,
        SRA   = 5'd12,
        AND   = 5'd13,
        NO_OP = 5'd14
    } alu_ctrl_e;

    // operand source for forwarding.
    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_EX = 2'd1,
        FWD_WB = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic [XLEN-1:0]   op_a;
        logic [XLEN-1:0]   op_b;
        alu_ctrl_e         alu_ctrl;
        logic [REG_AW-1:0] rd;
        logic              we;
        logic              btype;     // branch instruction.
        logic [XLEN-1:0]   next_pc;   // branch target.
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]   result;
        logic [REG_AW-1:0] rd;
        logic              we;
    } ex_mem_t;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic [ex_pkg::REG_AW-1:0]      raddr_a_i,
    input  logic [ex_pkg::REG_AW-1:0]      raddr_b_i,
    input  logic                           we_i,
    input  logic [ex_pkg::REG_AW-1:0]      waddr_i,
    input  logic [ex_pkg::XLEN-1:0]        wdata_i,
    output logic [ex_pkg::XLEN-1:0]        rdata_a_o,
    output logic [ex_pkg::XLEN-1:0]        rdata_b_o
);

    logic [ex_pkg::XLEN-1:0] regs [2**ex_pkg::REG_AW];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**ex_pkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin   // x0 stays zero.
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- hdl/operand_fetch.sv
`timescale 1ns/100ps

module operand_fetch (
    input  logic [ex_pkg::XLEN-1:0]   rf_a_i,
    input  logic [ex_pkg::XLEN-1:0]   rf_b_i,
    input  logic [ex_pkg::XLEN-1:0]   ex_result_i,
    input  logic [ex_pkg::XLEN-1:0]   wb_data_i,
    input  logic [ex_pkg::XLEN-1:0]   imm_i,
    input  logic                      use_imm_i,
    input  ex_pkg::fwd_sel_e          fwd_a_i,
    input  ex_pkg::fwd_sel_e          fwd_b_i,
    input  ex_pkg::alu_ctrl_e         alu_ctrl_i,
    input  logic [ex_pkg::REG_AW-1:0] rd_i,
    input  logic                      we_i,
    input  logic                      btype_i,
    input  logic [ex_pkg::XLEN-1:0]   next_pc_i,
    output ex_pkg::id_ex_t            payload_o
);

    logic [ex_pkg::XLEN-1:0] src_a;
    logic [ex_pkg::XLEN-1:0] src_b;

    function automatic logic [ex_pkg::XLEN-1:0] pick_src(
        input ex_pkg::fwd_sel_e        sel,
        input logic [ex_pkg::XLEN-1:0] rf_val,
        input logic [ex_pkg::XLEN-1:0] ex_val,
        input logic [ex_pkg::XLEN-1:0] wb_val
    );
        case (sel)
            ex_pkg::FWD_EX: return ex_val;
            ex_pkg::FWD_WB: return wb_val;
            default:        return rf_val;
        endcase
    endfunction

    assign src_a = pick_src(fwd_a_i, rf_a_i, ex_result_i, wb_data_i);
    assign src_b = pick_src(fwd_b_i, rf_b_i, ex_result_i, wb_data_i);

    always_comb begin
        payload_o          = '0;
        payload_o.op_a     = src_a;
        payload_o.op_b     = use_imm_i ? imm_i : src_b;   // immediate wins.
        payload_o.alu_ctrl = alu_ctrl_i;
        payload_o.rd       = rd_i;
        payload_o.we       = we_i;
        payload_o.btype    = btype_i;
        payload_o.next_pc  = next_pc_i;
    end

endmodule

//--- hdl/pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  logic     kill_i,
    input  payload_t payload_i,
    output logic     valid_o,
    output payload_t payload_o
);

    logic load;

    assign load = valid_i && !kill_i;

    // an empty slot carries a zero payload, so it never looks like a branch.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o   <= 1'b0;
            payload_o <= '0;
        end else begin
            valid_o   <= load;
            payload_o <= load ? payload_i : '0;
        end
    end

endmodule

//--- hdl/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  ex_pkg::id_ex_t            payload_i,
    output ex_pkg::ex_mem_t           payload_o,
    output logic                      branch_taken_o,
    output logic [ex_pkg::XLEN-1:0]   next_pc_o
);

    logic [ex_pkg::XLEN-1:0] op_a;
    logic [ex_pkg::XLEN-1:0] op_b;
    logic [4:0]              shamt;
    logic [ex_pkg::XLEN-1:0] result;

    assign op_a  = payload_i.op_a;
    assign op_b  = payload_i.op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (payload_i.alu_ctrl)
            ex_pkg::ADD:   result = op_a + op_b;
            ex_pkg::SUB:   result = op_a - op_b;
            ex_pkg::EQU:   result = (op_a == op_b) ? 32'd1 : 32'd0;
            ex_pkg::NEQ:   result = (op_a != op_b) ? 32'd1 : 32'd0;
            ex_pkg::SLT:   result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            ex_pkg::SGE:   result = ($signed(op_a) < $signed(op_b)) ? 32'd0 : 32'd1;
            ex_pkg::SLTU:  result = (op_a < op_b) ? 32'd1 : 32'd0;
            ex_pkg::SGEU:  result = (op_a < op_b) ? 32'd0 : 32'd1;
            ex_pkg::XOR:   result = op_a ^ op_b;
            ex_pkg::OR:    result = op_a | op_b;
            ex_pkg::SLL:   result = op_a << shamt;
            ex_pkg::SRL:   result = op_a >> shamt;
            ex_pkg::SRA:   result = $unsigned($signed(op_a) >>> shamt);
            ex_pkg::AND:   result = op_a & op_b;
            ex_pkg::NO_OP: result = '0;
            default:       result = '0;
        endcase
    end

    always_comb begin
        payload_o        = '0;
        payload_o.result = result;
        payload_o.rd     = payload_i.rd;
        payload_o.we     = payload_i.we;
    end

    // compare ops leave 1 here when the branch is taken.
    assign branch_taken_o = payload_i.btype && (result != '0);
    assign next_pc_o      = payload_i.next_pc;

endmodule

//--- hdl/pipe_ctrl.sv
`timescale 1ns/100ps

module pipe_ctrl (
    input  logic [ex_pkg::REG_AW-1:0] rs1_i,
    input  logic [ex_pkg::REG_AW-1:0] rs2_i,
    input  logic                      use_imm_i,
    input  logic                      ex_valid_i,
    input  logic [ex_pkg::REG_AW-1:0] ex_rd_i,
    input  logic                      ex_we_i,
    input  logic                      wb_valid_i,
    input  logic [ex_pkg::REG_AW-1:0] wb_rd_i,
    input  logic                      wb_we_i,
    input  logic                      branch_taken_i,
    output ex_pkg::fwd_sel_e          fwd_a_o,
    output ex_pkg::fwd_sel_e          fwd_b_o,
    output logic                      kill_o,
    output logic                      rf_we_o
);

    logic ex_fwd_ok;
    logic wb_fwd_ok;

    // ex result takes priority over write-back data.
    function automatic ex_pkg::fwd_sel_e pick_fwd(
        input logic [ex_pkg::REG_AW-1:0] rs,
        input logic                      ex_ok,
        input logic [ex_pkg::REG_AW-1:0] ex_rd,
        input logic                      wb_ok,
        input logic [ex_pkg::REG_AW-1:0] wb_rd
    );
        if (ex_ok && (rs == ex_rd)) begin
            return ex_pkg::FWD_EX;
        end else if (wb_ok && (rs == wb_rd)) begin
            return ex_pkg::FWD_WB;
        end
        return ex_pkg::FWD_RF;
    endfunction

    assign ex_fwd_ok = ex_valid_i && ex_we_i && (ex_rd_i != '0);
    assign wb_fwd_ok = wb_valid_i && wb_we_i && (wb_rd_i != '0);

    assign fwd_a_o = pick_fwd(rs1_i, ex_fwd_ok, ex_rd_i, wb_fwd_ok, wb_rd_i);
    assign fwd_b_o = use_imm_i ? ex_pkg::FWD_RF :
                     pick_fwd(rs2_i, ex_fwd_ok, ex_rd_i, wb_fwd_ok, wb_rd_i);

    assign kill_o  = branch_taken_i;   // squash the instruction behind.
    assign rf_we_o = wb_valid_i && wb_we_i;

endmodule

//--- hdl/ex_pipe_top.sv
`timescale 1ns/100ps

module ex_pipe_top (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      valid_i,
    input  ex_pkg::alu_ctrl_e         alu_ctrl_i,
    input  logic [ex_pkg::REG_AW-1:0] rs1_i,
    input  logic [ex_pkg::REG_AW-1:0] rs2_i,
    input  logic [ex_pkg::XLEN-1:0]   imm_i,
    input  logic                      use_imm_i,
    input  logic [ex_pkg::REG_AW-1:0] rd_i,
    input  logic                      we_i,
    input  logic                      btype_i,
    input  logic [ex_pkg::XLEN-1:0]   next_pc_i,
    output logic                      wb_valid_o,
    output logic [ex_pkg::REG_AW-1:0] wb_waddr_o,
    output logic [ex_pkg::XLEN-1:0]   wb_data_o,
    output logic                      branch_o,
    output logic [ex_pkg::XLEN-1:0]   next_pc_o,
    output logic                      flush_o
);

    logic [ex_pkg::XLEN-1:0] rf_a;
    logic [ex_pkg::XLEN-1:0] rf_b;
    ex_pkg::fwd_sel_e        fwd_a;
    ex_pkg::fwd_sel_e        fwd_b;
    ex_pkg::id_ex_t          id_ex_d;
    ex_pkg::id_ex_t          id_ex_q;
    logic                    id_ex_valid;
    ex_pkg::ex_mem_t         ex_mem_d;
    ex_pkg::ex_mem_t         ex_mem_q;
    logic                    ex_mem_valid;
    logic                    branch_taken;
    logic                    kill;
    logic                    rf_we;

    reg_file u_reg_file (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .raddr_a_i (rs1_i),
        .raddr_b_i (rs2_i),
        .we_i      (rf_we),
        .waddr_i   (ex_mem_q.rd),
        .wdata_i   (ex_mem_q.result),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b)
    );

    operand_fetch u_operand_fetch (
        .rf_a_i      (rf_a),
        .rf_b_i      (rf_b),
        .ex_result_i (ex_mem_d.result),
        .wb_data_i   (ex_mem_q.result),
        .imm_i       (imm_i),
        .use_imm_i   (use_imm_i),
        .fwd_a_i     (fwd_a),
        .fwd_b_i     (fwd_b),
        .alu_ctrl_i  (alu_ctrl_i),
        .rd_i        (rd_i),
        .we_i        (we_i),
        .btype_i     (btype_i),
        .next_pc_i   (next_pc_i),
        .payload_o   (id_ex_d)
    );

    pipe_reg #(.payload_t(ex_pkg::id_ex_t)) u_id_ex (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .valid_i   (valid_i),
        .kill_i    (kill),
        .payload_i (id_ex_d),
        .valid_o   (id_ex_valid),
        .payload_o (id_ex_q)
    );

    ex_stage u_ex_stage (
        .payload_i      (id_ex_q),
        .payload_o      (ex_mem_d),
        .branch_taken_o (branch_taken),
        .next_pc_o      (next_pc_o)
    );

    pipe_reg #(.payload_t(ex_pkg::ex_mem_t)) u_ex_mem (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .valid_i   (id_ex_valid),
        .kill_i    (1'b0),          // no stall or squash past ex.
        .payload_i (ex_mem_d),
        .valid_o   (ex_mem_valid),
        .payload_o (ex_mem_q)
    );

    pipe_ctrl u_pipe_ctrl (
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .use_imm_i      (use_imm_i),
        .ex_valid_i     (id_ex_valid),
        .ex_rd_i        (id_ex_q.rd),
        .ex_we_i        (id_ex_q.we),
        .wb_valid_i     (ex_mem_valid),
        .wb_rd_i        (ex_mem_q.rd),
        .wb_we_i        (ex_mem_q.we),
        .branch_taken_i (branch_taken),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b),
        .kill_o         (kill),
        .rf_we_o        (rf_we)
    );

    assign wb_valid_o = rf_we;
    assign wb_waddr_o = ex_mem_q.rd;
    assign wb_data_o  = ex_mem_q.result;
    assign branch_o   = branch_taken;
    assign flush_o    = branch_taken;

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;   // 4 ns period.
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

//--- test/tb_ex_pipe.sv
`timescale 1ns/100ps

module tb_ex_pipe;

    logic        clk;
    logic        arst_n;
    logic        valid;
    logic [4:0]  code;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        use_imm;
    logic [4:0]  rd;
    logic        we;
    logic        btype;
    logic [31:0] npc;
    logic        wb_valid;
    logic [4:0]  wb_waddr;
    logic [31:0] wb_data;
    logic        branch;
    logic [31:0] next_pc;
    logic        flush;

    // model of the pipeline stages.
    logic        s1_valid;
    logic        s1_we;
    logic        s1_btype;
    logic        s2_valid;
    logic        s2_we;
    logic [4:0]  s1_rd;
    logic [4:0]  s2_rd;
    logic [31:0] s1_result;
    logic [31:0] s1_pc;
    logic [31:0] s2_result;
    logic [31:0] shadow [32];
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          wait_cnt;

    tb_clk_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

    ex_pipe_top i_dut (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .valid_i    (valid),
        .alu_ctrl_i (ex_pkg::alu_ctrl_e'(code)),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .imm_i      (imm),
        .use_imm_i  (use_imm),
        .rd_i       (rd),
        .we_i       (we),
        .btype_i    (btype),
        .next_pc_i  (npc),
        .wb_valid_o (wb_valid),
        .wb_waddr_o (wb_waddr),
        .wb_data_o  (wb_data),
        .branch_o   (branch),
        .next_pc_o  (next_pc),
        .flush_o    (flush)
    );

    // galois lfsr, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000)
                                       : (lfsr_state >> 1);
        end
        return val;
    endfunction

    function automatic logic [31:0] alu_ref(
        input logic [4:0]  op,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (op)
            5'd0:    return a + b;
            5'd1:    return a - b;
            5'd2:    return {31'd0, a == b};
            5'd3:    return {31'd0, a != b};
            5'd4:    return {31'd0, sa < sb};
            5'd5:    return {31'd0, sa >= sb};
            5'd6:    return {31'd0, a < b};
            5'd7:    return {31'd0, a >= b};
            5'd8:    return a ^ b;
            5'd9:    return a | b;
            5'd10:   return a << b[4:0];
            5'd11:   return a >> b[4:0];
            5'd12:   return sa >>> b[4:0];
            5'd13:   return a & b;
            default: return 32'd0;   // no-op and unused codes.
        endcase
    endfunction

    // newest value of a register as seen by the next instruction.
    function automatic logic [31:0] src_val(input logic [4:0] r);
        if (r == 5'd0) return 32'd0;
        if (s1_valid && s1_we && (s1_rd == r)) return s1_result;
        if (s2_valid && s2_we && (s2_rd == r)) return s2_result;
        return shadow[r];
    endfunction

    task automatic issue(
        input logic        v,
        input logic [4:0]  op,
        input logic [4:0]  a,
        input logic [4:0]  b,
        input logic [31:0] im,
        input logic        ui,
        input logic [4:0]  d,
        input logic        w,
        input logic        bt,
        input logic [31:0] pc
    );
        @(negedge clk);
        valid   = v;
        code    = op;
        rs1     = a;
        rs2     = b;
        imm     = im;
        use_imm = ui;
        rd      = d;
        we      = w;
        btype   = bt;
        npc     = pc;
    endtask

    always @(posedge clk) begin : compare_proc
        logic        br_exp;
        logic        wb_exp;
        logic [31:0] a;
        logic [31:0] b;
        if (!arst_n) begin
            s1_valid = 1'b0;
            s2_valid = 1'b0;
            for (int i = 0; i < 32; i++) shadow[i] = '0;
        end else begin
            br_exp = s1_valid && s1_btype && (s1_result != 0);
            wb_exp = s2_valid && s2_we;
            checks++;
            if (branch !== br_exp || flush !== br_exp) begin
                $display("ERROR %0t: branch/flush %b/%b, expected %b", $time, branch,
                         flush, br_exp);
                errors++;
            end
            if (br_exp && next_pc !== s1_pc) begin
                $display("ERROR %0t: next_pc_o is %h, expected %h", $time, next_pc, s1_pc);
                errors++;
            end
            if (wb_valid !== wb_exp) begin
                $display("ERROR %0t: wb_valid_o is %b, expected %b", $time, wb_valid, wb_exp);
                errors++;
            end
            if (wb_exp && (wb_waddr !== s2_rd || wb_data !== s2_result)) begin
                $display("ERROR %0t: write-back x%0d=%h, expected x%0d=%h", $time,
                         wb_waddr, wb_data, s2_rd, s2_result);
                errors++;
            end
            a = src_val(rs1);
            b = use_imm ? imm : src_val(rs2);
            if (wb_exp && s2_rd != 0) shadow[s2_rd] = s2_result;
            s2_valid  = s1_valid;
            s2_result = s1_result;
            s2_rd     = s1_rd;
            s2_we     = s1_we;
            s1_valid  = valid && !br_exp;   // squash behind a taken branch.
            s1_result = alu_ref(code, a, b);
            s1_rd     = rd;
            s1_we     = we;
            s1_btype  = btype;
            s1_pc     = npc;
        end
    end

    initial begin
        errors = 0;
        checks = 0;
        lfsr_state = 32'h1030_9d8c;
        valid = 0;
        code = 0;
        rs1 = 0;
        rs2 = 0;
        imm = 0;
        use_imm = 0;
        rd = 0;
        we = 0;
        btype = 0;
        npc = 0;
        wait_cnt = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 100) begin
                $display("timeout: reset was never released");
                $display("Simulation failed");
                $finish;
            end
        end
        if (wb_valid !== 1'b0 || branch !== 1'b0 || flush !== 1'b0) begin
            $display("ERROR %0t: outputs not low after reset", $time);
            errors++;
        end
        issue(1, 5'd0, 5'd20, 5'd21, 0, 0, 5'd1, 1, 0, 0);   // unwritten sources.
        for (int k = 1; k < 8; k++) issue(1, 5'd0, 0, 0, rand_bits(32), 1, k[4:0], 1, 0, 0);
        for (int c = 0; c < 16; c++) begin
            issue(1, c[4:0], rand_bits(3), rand_bits(3), rand_bits(32), rand_bits(1),
                  5'd8 + c[4:0], 1, 0, 0);
        end
        // forwarding at distance one and two.
        issue(1, 5'd0, 5'd1, 0, 32'h11, 1, 5'd9, 1, 0, 0);
        issue(1, 5'd0, 5'd9, 5'd9, 0, 0, 5'd10, 1, 0, 0);
        issue(1, 5'd1, 5'd10, 5'd9, 0, 0, 5'd11, 1, 0, 0);
        // taken branch squashes the next one, then an untaken branch.
        issue(1, 5'd2, 5'd1, 5'd1, 0, 0, 5'd0, 0, 1, 32'h0000_0100);
        issue(1, 5'd0, 5'd0, 0, 32'h55, 1, 5'd12, 1, 0, 0);
        issue(1, 5'd1, 5'd2, 5'd2, 0, 0, 5'd0, 0, 1, 32'h0000_0200);
        // x0 and disabled writes.
        issue(1, 5'd0, 0, 0, 32'hdead, 1, 5'd0, 1, 0, 0);
        issue(1, 5'd0, 0, 0, 32'hbeef, 1, 5'd13, 0, 0, 0);
        issue(1, 5'd9, 5'd0, 5'd13, 0, 0, 5'd14, 1, 0, 0);
        for (int n = 0; n < 3000; n++) begin
            issue(rand_bits(2) != 0, rand_bits(4), rand_bits(5), rand_bits(5), rand_bits(32),
                  rand_bits(1), rand_bits(5), rand_bits(3) != 0, rand_bits(3) == 0,
                  rand_bits(32));
        end
        issue(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        wait_cnt = 0;
        while (s1_valid || s2_valid) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 20) begin
                $display("timeout: pipeline did not drain");
                $display("Simulation failed");
                $finish;
            end
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/ex_pkg.sv
hdl/reg_file.sv
hdl/operand_fetch.sv
hdl/pipe_reg.sv
hdl/ex_stage.sv
hdl/pipe_ctrl.sv
hdl/ex_pipe_top.sv
test/tb_clk_gen.sv
test/tb_ex_pipe.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the execute-slice testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_ex_pipe -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Simulation completed successfully" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
